// ==== Bender.yml ====
package:
  name: ppu

sources:
  - common/ppu_pkg.sv
  - src/ppu_regs.sv
  - src/oam_dma.sv
  - src/oam_arbiter.sv
  - src/lcd_timing.sv
  - bg/bg_fetcher.sv
  - bg/pixel_output.sv
  - src/ppu_top.sv
  - target: test
    files:
      - tb/ppu_assertions.sv
      - tb/ppu_tb.sv

// ==== all.f ====
common/ppu_pkg.sv
src/ppu_regs.sv
src/oam_dma.sv
src/oam_arbiter.sv
src/lcd_timing.sv
bg/bg_fetcher.sv
bg/pixel_output.sv
src/ppu_top.sv
tb/ppu_assertions.sv
tb/ppu_tb.sv

// ==== bg/bg_fetcher.sv ====
`timescale 1ns/1ps

module bg_fetcher (
	input  logic             clk,
	input  logic             reset,
	input  ppu_pkg::bg_cfg_t cfg,
	input  ppu_pkg::timing_t timing,
	input  logic [7:0]       vram_data,
	output logic             vram_rd,
	output logic [12:0]      vram_addr,
	output logic [1:0]       pix,
	output logic             pix_valid
);
	import ppu_pkg::*;

	// each of map, data0 and data1 takes this many dots
	localparam int unsigned STAGE_DOTS = FETCH_DOTS / 3;

	fetch_state_e state;
	logic         phase;
	logic [4:0]   tile_cnt;
	logic [3:0]   shift_cnt;
	logic [7:0]   shift_lo;
	logic [7:0]   shift_hi;
	logic [7:0]   tile_idx;
	logic [7:0]   data0;
	logic [7:0]   data1;
	logic         run;
	logic         stage_end;
	logic         load;
	logic [7:0]   bg_row;
	logic [4:0]   map_col;
	logic         tile_a12;

	// only active while drawing, restarts on every line
	assign run       = (timing.mode == MODE_DRAW) && !timing.line_start;
	assign stage_end = (phase == 1'(STAGE_DOTS - 1));
	assign load      = run && (state == FETCH_WAIT) && (shift_cnt == 4'd0);

	// --------------------
	// fetch sequence
	always_ff @(posedge clk) begin
		if (reset || !run) begin
			state     <= FETCH_MAP;
			phase     <= 1'b0;
			tile_cnt  <= 5'd0;
			shift_cnt <= 4'd0;
		end else begin
			if (shift_cnt != 4'd0)
				shift_cnt <= shift_cnt - 4'd1;
			case (state)
				FETCH_MAP, FETCH_DATA0: begin
					phase <= ~phase;
					if (stage_end)
						state <= (state == FETCH_MAP) ? FETCH_DATA0 : FETCH_DATA1;
				end
				FETCH_DATA1: begin
					phase <= ~phase;
					if (stage_end) begin
						state    <= FETCH_WAIT;
						tile_cnt <= tile_cnt + 5'd1;
					end
				end
				// hold the tile until the shifter runs dry
				default: begin
					if (shift_cnt == 4'd0) begin
						state     <= FETCH_MAP;
						shift_cnt <= 4'd8;
					end
				end
			endcase
		end
	end

	// --------------------
	// vram capture and shifter
	always_ff @(posedge clk) begin
		if (run && stage_end) begin
			if (state == FETCH_MAP)
				tile_idx <= vram_data;
			if (state == FETCH_DATA0)
				data0 <= vram_data;
			if (state == FETCH_DATA1)
				data1 <= vram_data;
		end
		if (load) begin
			shift_lo <= data0;
			shift_hi <= data1;
		end else if (run && shift_cnt != 4'd0) begin
			shift_lo <= shift_lo << 1;
			shift_hi <= shift_hi << 1;
		end
	end

	// leftmost pixel sits in bit 7
	assign pix       = {shift_hi[7], shift_lo[7]};
	assign pix_valid = run && (shift_cnt != 4'd0);

	// --------------------
	// vram addressing
	assign bg_row  = timing.ly + cfg.scy;
	assign map_col = cfg.scx[7:3] + tile_cnt;

	// tile_sel 0 means signed index around 9000h
	assign tile_a12 = cfg.lcdc.tile_sel ? 1'b0 : ~tile_idx[7];

	always_comb begin
		case (state)
			FETCH_MAP:   vram_addr = {2'b11, cfg.lcdc.bg_map, bg_row[7:3], map_col};
			FETCH_DATA0: vram_addr = {tile_a12, tile_idx, bg_row[2:0], 1'b0};
			default:     vram_addr = {tile_a12, tile_idx, bg_row[2:0], 1'b1};
		endcase
	end

	assign vram_rd = run && (state != FETCH_WAIT);

endmodule

// ==== bg/pixel_output.sv ====
`timescale 1ns/1ps

module pixel_output (
	input  logic             clk,
	input  logic             reset,
	input  ppu_pkg::bg_cfg_t cfg,
	input  ppu_pkg::timing_t timing,
	input  logic [1:0]       pix,
	input  logic             pix_valid,
	output logic             lcd_clkena,
	output logic [1:0]       lcd_data,
	output logic             last_pix
);
	import ppu_pkg::*;

	logic [2:0] skip;
	logic [7:0] pix_cnt;
	logic [1:0] color;
	logic [1:0] shade;

	// bg disabled forces colour 0
	assign color = cfg.lcdc.bg_ena ? pix : 2'd0;
	assign shade = cfg.bgp[{color, 1'b0} +: 2];

	always_ff @(posedge clk) begin
		if (reset || !cfg.lcdc.on) begin
			// blank output while the lcd is off
			lcd_clkena <= 1'b0;
			lcd_data   <= 2'd0;
			last_pix   <= 1'b0;
			skip       <= 3'd0;
			pix_cnt    <= 8'd0;
		end else begin
			lcd_clkena <= 1'b0;
			last_pix   <= 1'b0;
			if (timing.line_start) begin
				// fine scroll, drop the first scx mod 8 pixels
				skip    <= cfg.scx[2:0];
				pix_cnt <= 8'd0;
			end else if (pix_valid) begin
				if (skip != 3'd0) begin
					skip <= skip - 3'd1;
				end else if (pix_cnt < 8'(SCREEN_W)) begin
					lcd_clkena <= 1'b1;
					lcd_data   <= shade;
					pix_cnt    <= pix_cnt + 8'd1;
					last_pix   <= (pix_cnt == 8'(SCREEN_W - 1));
				end
			end
		end
	end

endmodule

// ==== common/ppu_pkg.sv ====
package ppu_pkg;

	// --------------------
	// frame geometry, one clk per dot
	localparam int unsigned DOTS_PER_LINE   = 456;
	localparam int unsigned LINES_PER_FRAME = 154;
	localparam int unsigned OAM_SCAN_DOTS   = 80;
	localparam int unsigned VISIBLE_LINES   = 144;
	localparam int unsigned SCREEN_W        = 160;

	// oam size and dma run length, four dots per byte
	localparam int unsigned OAM_BYTES  = 160;
	localparam int unsigned DMA_DOTS   = 640;
	// three fetch stages of two dots each
	localparam int unsigned FETCH_DOTS = 6;

	// palette values after reset
	localparam logic [7:0] BGP_RESET = 8'hfc;
	localparam logic [7:0] OBP_RESET = 8'hff;

	// --------------------
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_DRAW   = 2'd3
	} ppu_mode_e;

	// register offsets inside the ff40 block
	typedef enum logic [7:0] {
		REG_LCDC = 8'h40,
		REG_STAT = 8'h41,
		REG_SCY  = 8'h42,
		REG_SCX  = 8'h43,
		REG_LY   = 8'h44,
		REG_LYC  = 8'h45,
		REG_DMA  = 8'h46,
		REG_BGP  = 8'h47,
		REG_OBP0 = 8'h48,
		REG_OBP1 = 8'h49
	} reg_addr_e;

	typedef enum logic [2:0] {
		FETCH_MAP,
		FETCH_DATA0,
		FETCH_DATA1,
		FETCH_WAIT
	} fetch_state_e;

	// --------------------
	typedef struct packed {
		logic       sel_oam;
		logic       sel_reg;
		logic       wr;
		logic [7:0] addr;
		logic [7:0] wdata;
	} cpu_bus_t;

	// lcdc bit 7 down to bit 0
	typedef struct packed {
		logic on;
		logic win_map;
		logic win_ena;
		logic tile_sel;
		logic bg_map;
		logic spr_size;
		logic spr_ena;
		logic bg_ena;
	} lcdc_t;

	typedef struct packed {
		lcdc_t      lcdc;
		logic [7:0] scx;
		logic [7:0] scy;
		logic [7:0] bgp;
	} bg_cfg_t;

	typedef struct packed {
		logic       wr;
		logic [7:0] addr;
		logic [7:0] data;
	} oam_wr_t;

	typedef struct packed {
		logic [8:0] h_cnt;
		logic [7:0] ly;
		ppu_mode_e  mode;
		logic       line_start;
	} timing_t;

endpackage

// ==== src/lcd_timing.sv ====
`timescale 1ns/1ps

module lcd_timing (
	input  logic             clk,
	input  logic             reset,
	input  logic             lcd_on,
	input  logic [3:0]       stat_ena,
	input  logic [7:0]       lyc,
	input  logic             last_pix,
	output ppu_pkg::timing_t timing,
	output logic             lyc_match,
	output logic             irq,
	output logic             vblank_irq,
	output logic             lcd_vsync
);
	import ppu_pkg::*;

	logic [8:0] h_cnt;
	logic [7:0] ly_q;
	ppu_mode_e  mode_q;
	logic [8:0] h_next;
	logic [7:0] ly_next;
	ppu_mode_e  mode_next;
	ppu_mode_e  mode;
	logic [7:0] ly;

	// --------------------
	// next dot position
	always_comb begin
		h_next  = h_cnt + 9'd1;
		ly_next = ly_q;
		if (h_cnt == 9'(DOTS_PER_LINE - 1)) begin
			h_next  = 9'd0;
			ly_next = (ly_q == 8'(LINES_PER_FRAME - 1)) ? 8'd0 : ly_q + 8'd1;
		end
	end

	// mode for the next dot, so the register lines up with h_cnt
	always_comb begin
		if (ly_next >= 8'(VISIBLE_LINES))
			mode_next = MODE_VBLANK;
		else if (h_next < 9'(OAM_SCAN_DOTS))
			mode_next = MODE_OAM;
		else if (h_next == 9'(OAM_SCAN_DOTS))
			mode_next = MODE_DRAW;
		else if (mode_q == MODE_DRAW && last_pix)
			// draw ends once the last pixel has gone out
			mode_next = MODE_HBLANK;
		else
			mode_next = mode_q;
	end

	always_ff @(posedge clk) begin
		if (reset || !lcd_on) begin
			// parked at the first dot of line 0
			h_cnt  <= 9'd0;
			ly_q   <= 8'd0;
			mode_q <= MODE_OAM;
		end else begin
			h_cnt  <= h_next;
			ly_q   <= ly_next;
			mode_q <= mode_next;
		end
	end

	// lcd off shows hblank and line 0
	assign mode = lcd_on ? mode_q : MODE_HBLANK;
	assign ly   = lcd_on ? ly_q : 8'd0;

	assign timing = '{
		h_cnt:      h_cnt,
		ly:         ly,
		mode:       mode,
		line_start: lcd_on && (h_cnt == 9'd0)
	};

	// --------------------
	// interrupts
	assign lyc_match = (ly == lyc);

	// stat enables: lyc, oam, vblank, hblank
	assign irq = lcd_on && (
		(stat_ena[3] && lyc_match) ||
		(stat_ena[2] && mode == MODE_OAM) ||
		(stat_ena[1] && mode == MODE_VBLANK) ||
		(stat_ena[0] && mode == MODE_HBLANK));

	assign vblank_irq = lcd_on && (ly >= 8'(VISIBLE_LINES));
	assign lcd_vsync  = lcd_on && (ly == 8'd0);

endmodule

// ==== src/oam_arbiter.sv ====
`timescale 1ns/1ps

module oam_arbiter (
	input  logic             clk,
	input  ppu_pkg::oam_wr_t cpu_oam,
	input  ppu_pkg::oam_wr_t dma_oam,
	input  logic             dma_active,
	input  logic [7:0]       rd_addr,
	output logic [7:0]       oam_rdata
);
	import ppu_pkg::*;

	logic [7:0] mem [OAM_BYTES];
	oam_wr_t    grant;

	// dma owns the port for its whole run, cpu writes are dropped
	assign grant = dma_active ? dma_oam : cpu_oam;

	// --------------------
	// storage
	always_ff @(posedge clk) begin
		// addresses a0..ff fall outside the array
		if (grant.wr && (grant.addr < 8'(OAM_BYTES)))
			mem[grant.addr] <= grant.data;
	end

	// unused area reads back as all ones
	assign oam_rdata = (rd_addr < 8'(OAM_BYTES)) ? mem[rd_addr] : 8'hff;

endmodule

// ==== src/oam_dma.sv ====
`timescale 1ns/1ps

module oam_dma (
	input  logic             clk,
	input  logic             reset,
	input  logic             dma_start,
	input  logic [7:0]       dma_page,
	input  logic [7:0]       dma_data,
	output logic             dma_rd,
	output logic [15:0]      dma_addr,
	output ppu_pkg::oam_wr_t dma_oam
);
	import ppu_pkg::*;

	logic       active;
	// dot counter, byte index in the upper eight bits
	logic [9:0] cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			cnt    <= 10'd0;
		end else if (dma_start) begin
			// a new page write restarts the run
			active <= 1'b1;
			cnt    <= 10'd0;
		end else if (active) begin
			if (cnt == 10'(DMA_DOTS - 1))
				active <= 1'b0;
			else
				cnt <= cnt + 10'd1;
		end
	end

	assign dma_rd   = active;
	assign dma_addr = {dma_page, cnt[9:2]};

	// source byte is stable by the third dot of each slot
	assign dma_oam = '{
		wr:   active && (cnt[1:0] == 2'd2),
		addr: cnt[9:2],
		data: dma_data
	};

endmodule

// ==== src/ppu_regs.sv ====
`timescale 1ns/1ps

module ppu_regs (
	input  logic              clk,
	input  logic              reset,
	input  ppu_pkg::cpu_bus_t cpu,
	input  ppu_pkg::timing_t  timing,
	input  logic              lyc_match,
	input  logic [7:0]        oam_rdata,
	output logic [7:0]        cpu_rdata,
	output ppu_pkg::bg_cfg_t  cfg,
	output logic [3:0]        stat_ena,
	output logic [7:0]        lyc,
	output logic [7:0]        dma_page,
	output logic              dma_start,
	output ppu_pkg::oam_wr_t  cpu_oam
);
	import ppu_pkg::*;

	lcdc_t      lcdc;
	logic [7:0] scy;
	logic [7:0] scx;
	logic [7:0] bgp;
	logic [7:0] obp0;
	logic [7:0] obp1;
	reg_addr_e  reg_addr;
	logic       reg_wr;

	assign reg_addr = reg_addr_e'(cpu.addr);
	assign reg_wr   = cpu.sel_reg && cpu.wr;

	// --------------------
	// write decode
	always_ff @(posedge clk) begin
		if (reset) begin
			// lcd starts off
			lcdc     <= '0;
			stat_ena <= 4'd0;
			scy      <= 8'd0;
			scx      <= 8'd0;
			lyc      <= 8'd0;
			dma_page <= 8'd0;
			bgp      <= BGP_RESET;
			obp0     <= OBP_RESET;
			obp1     <= OBP_RESET;
		end else if (reg_wr) begin
			case (reg_addr)
				REG_LCDC: lcdc     <= lcdc_t'(cpu.wdata);
				// only the four enable bits are writable
				REG_STAT: stat_ena <= cpu.wdata[6:3];
				REG_SCY:  scy      <= cpu.wdata;
				REG_SCX:  scx      <= cpu.wdata;
				REG_LYC:  lyc      <= cpu.wdata;
				REG_DMA:  dma_page <= cpu.wdata;
				REG_BGP:  bgp      <= cpu.wdata;
				REG_OBP0: obp0     <= cpu.wdata;
				REG_OBP1: obp1     <= cpu.wdata;
				// ly is read only
				default: ;
			endcase
		end
	end

	// dma kicks off in the same cycle the page is written
	assign dma_start = reg_wr && (reg_addr == REG_DMA);

	assign cfg = '{lcdc: lcdc, scx: scx, scy: scy, bgp: bgp};

	// oam is owned by the video side during scan and draw
	assign cpu_oam = '{
		wr:   cpu.sel_oam && cpu.wr &&
		      !(timing.mode == MODE_OAM || timing.mode == MODE_DRAW),
		addr: cpu.addr,
		data: cpu.wdata
	};

	// --------------------
	// read mux
	always_comb begin
		if (cpu.sel_oam) begin
			cpu_rdata = oam_rdata;
		end else begin
			case (reg_addr)
				REG_LCDC: cpu_rdata = lcdc;
				// bit 7 always reads as one
				REG_STAT: cpu_rdata = {1'b1, stat_ena, lyc_match, timing.mode};
				REG_SCY:  cpu_rdata = scy;
				REG_SCX:  cpu_rdata = scx;
				REG_LY:   cpu_rdata = timing.ly;
				REG_LYC:  cpu_rdata = lyc;
				REG_DMA:  cpu_rdata = dma_page;
				REG_BGP:  cpu_rdata = bgp;
				REG_OBP0: cpu_rdata = obp0;
				REG_OBP1: cpu_rdata = obp1;
				default:  cpu_rdata = 8'hff;
			endcase
		end
	end

endmodule

// ==== src/ppu_top.sv ====
`timescale 1ns/1ps

module ppu_top (
	input  logic              clk,
	input  logic              reset,
	input  ppu_pkg::cpu_bus_t cpu,
	output logic [7:0]        cpu_rdata,
	output logic              vram_rd,
	output logic [12:0]       vram_addr,
	input  logic [7:0]        vram_data,
	output logic              dma_rd,
	output logic [15:0]       dma_addr,
	input  logic [7:0]        dma_data,
	output logic              lcd_on,
	output logic              lcd_clkena,
	output logic              lcd_vsync,
	output logic              irq,
	output logic              vblank_irq,
	output logic [1:0]        lcd_data
);
	import ppu_pkg::*;

	bg_cfg_t    cfg;
	timing_t    timing;
	oam_wr_t    cpu_oam;
	oam_wr_t    dma_oam;
	logic [3:0] stat_ena;
	logic [7:0] lyc;
	logic       lyc_match;
	logic [7:0] dma_page;
	logic       dma_start;
	logic [7:0] oam_rdata;
	logic [1:0] pix;
	logic       pix_valid;
	logic       last_pix;

	assign lcd_on = cfg.lcdc.on;

	// --------------------
	// cpu side
	ppu_regs u_ppu_regs (
		.clk       (clk),
		.reset     (reset),
		.cpu       (cpu),
		.timing    (timing),
		.lyc_match (lyc_match),
		.oam_rdata (oam_rdata),
		.cpu_rdata (cpu_rdata),
		.cfg       (cfg),
		.stat_ena  (stat_ena),
		.lyc       (lyc),
		.dma_page  (dma_page),
		.dma_start (dma_start),
		.cpu_oam   (cpu_oam)
	);

	oam_dma u_oam_dma (
		.clk       (clk),
		.reset     (reset),
		.dma_start (dma_start),
		.dma_page  (dma_page),
		.dma_data  (dma_data),
		.dma_rd    (dma_rd),
		.dma_addr  (dma_addr),
		.dma_oam   (dma_oam)
	);

	// dma_rd doubles as the dma busy flag for the arbiter
	oam_arbiter u_oam_arbiter (
		.clk        (clk),
		.cpu_oam    (cpu_oam),
		.dma_oam    (dma_oam),
		.dma_active (dma_rd),
		.rd_addr    (cpu.addr),
		.oam_rdata  (oam_rdata)
	);

	// --------------------
	// video side
	lcd_timing u_lcd_timing (
		.clk        (clk),
		.reset      (reset),
		.lcd_on     (cfg.lcdc.on),
		.stat_ena   (stat_ena),
		.lyc        (lyc),
		.last_pix   (last_pix),
		.timing     (timing),
		.lyc_match  (lyc_match),
		.irq        (irq),
		.vblank_irq (vblank_irq),
		.lcd_vsync  (lcd_vsync)
	);

	bg_fetcher u_bg_fetcher (
		.clk       (clk),
		.reset     (reset),
		.cfg       (cfg),
		.timing    (timing),
		.vram_data (vram_data),
		.vram_rd   (vram_rd),
		.vram_addr (vram_addr),
		.pix       (pix),
		.pix_valid (pix_valid)
	);

	pixel_output u_pixel_output (
		.clk        (clk),
		.reset      (reset),
		.cfg        (cfg),
		.timing     (timing),
		.pix        (pix),
		.pix_valid  (pix_valid),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data),
		.last_pix   (last_pix)
	);

endmodule

// ==== tb/ppu_assertions.sv ====
`timescale 1ns/1ps

module ppu_assertions (
	input logic             clk,
	input logic             reset,
	input ppu_pkg::timing_t timing,
	input logic             lcd_clkena
);
	import ppu_pkg::*;

	// no drawing on the vblank lines
	a_no_draw_in_vblank: assert property (@(posedge clk) disable iff (reset)
		(timing.ly >= 8'(VISIBLE_LINES)) |-> (timing.mode != MODE_DRAW))
		else $error("mode is DRAW on vblank line %0d", timing.ly);

	// pixels only go out while drawing
	a_strobe_in_draw: assert property (@(posedge clk) disable iff (reset)
		lcd_clkena |-> (timing.mode == MODE_DRAW))
		else $error("pixel strobe while mode is %s", timing.mode.name());

	// oam scan always starts a line
	a_oam_entry: assert property (@(posedge clk) disable iff (reset)
		((timing.mode == MODE_OAM) && ($past(timing.mode) != MODE_OAM)) |->
		(timing.h_cnt == 9'd0))
		else $error("mode entered OAM at h_cnt %0d", timing.h_cnt);

endmodule

bind ppu_top ppu_assertions u_ppu_assertions (
	.clk        (clk),
	.reset      (reset),
	.timing     (timing),
	.lcd_clkena (lcd_clkena)
);

// ==== tb/ppu_tb.sv ====
`timescale 1ns/1ps

module ppu_tb;
	import ppu_pkg::*;

	localparam int CLK_PERIOD = 100;
	// sample point a quarter period after the falling edge
	localparam int SAMPLE_DLY = CLK_PERIOD / 4;
	// three frames and one dma run plus room for register and oam traffic
	localparam int TIMEOUT_CYCLES = 3 * DOTS_PER_LINE * LINES_PER_FRAME + DMA_DOTS + 4000;

	logic        clk;
	logic        reset;
	cpu_bus_t    cpu;
	logic [7:0]  cpu_rdata;
	logic        vram_rd;
	logic [12:0] vram_addr;
	logic [7:0]  vram_data;
	logic        dma_rd;
	logic [15:0] dma_addr;
	logic [7:0]  dma_data;
	logic        lcd_on;
	logic        lcd_clkena;
	logic        lcd_vsync;
	logic        irq;
	logic        vblank_irq;
	logic [1:0]  lcd_data;

	// models of the outside memories
	logic [7:0]  vram [8192];
	logic [15:0] lfsr_state;
	int          error_count;
	int          cycle_count;

	// register values the model expects
	lcdc_t       lcdc_m;
	logic [7:0]  scx_m;
	logic [7:0]  scy_m;
	logic [7:0]  bgp_m;
	logic [7:0]  lyc_m;

	ppu_top u_ppu_top (
		.clk        (clk),
		.reset      (reset),
		.cpu        (cpu),
		.cpu_rdata  (cpu_rdata),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data),
		.dma_rd     (dma_rd),
		.dma_addr   (dma_addr),
		.dma_data   (dma_data),
		.lcd_on     (lcd_on),
		.lcd_clkena (lcd_clkena),
		.lcd_vsync  (lcd_vsync),
		.irq        (irq),
		.vblank_irq (vblank_irq),
		.lcd_data   (lcd_data)
	);

	// both memories answer in the same cycle
	assign vram_data = vram[vram_addr];
	// dma source pattern
	assign dma_data  = dma_addr[7:0] ^ 8'ha5;

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run($sformatf("timeout: the run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
	end

	// --------------------
	// random numbers
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		// galois form with taps 16 14 13 11
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// --------------------
	// error handling and compares
	task automatic abort_run(input string line);
		error_count++;
		$display("%s", line);
		$display("sim failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t ns: %s is %02h, expected %02h",
				$time, what, got, exp));
	endtask

	task automatic check_mode(input ppu_mode_e got, input ppu_mode_e exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t ns: %s is %s, expected %s",
				$time, what, got.name(), exp.name()));
	endtask

	task automatic check_pixel(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// --------------------
	// cpu bus tasks are all called at a falling edge
	task automatic drive_bus(input logic sel_oam, input logic sel_reg, input logic wr,
		input logic [7:0] addr, input logic [7:0] wdata);
		cpu = '{sel_oam: sel_oam, sel_reg: sel_reg, wr: wr, addr: addr, wdata: wdata};
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [7:0] data);
		drive_bus(1'b0, 1'b1, 1'b1, addr, data);
		@(negedge clk);
		drive_bus(1'b0, 1'b0, 1'b0, 8'h00, 8'h00);
	endtask

	task automatic reg_read(input logic [7:0] addr, output logic [7:0] data);
		drive_bus(1'b0, 1'b1, 1'b0, addr, 8'h00);
		#(SAMPLE_DLY);
		data = cpu_rdata;
		@(negedge clk);
	endtask

	task automatic oam_write(input logic [7:0] addr, input logic [7:0] data);
		drive_bus(1'b1, 1'b0, 1'b1, addr, data);
		@(negedge clk);
		drive_bus(1'b0, 1'b0, 1'b0, 8'h00, 8'h00);
	endtask

	task automatic oam_read(input logic [7:0] addr, output logic [7:0] data);
		drive_bus(1'b1, 1'b0, 1'b0, addr, 8'h00);
		#(SAMPLE_DLY);
		data = cpu_rdata;
		@(negedge clk);
	endtask

	// --------------------
	// background pixel model from the map and tile addressing
	function automatic logic [1:0] model_pixel(input int x, input int line);
		logic [7:0]  col;
		logic [7:0]  row;
		logic [12:0] map_addr;
		logic [7:0]  idx;
		logic [12:0] base;
		logic [7:0]  lo;
		logic [7:0]  hi;
		logic [1:0]  color;
		int          bit_pos;
		col = 8'(x + int'(scx_m));
		row = 8'(line + int'(scy_m));
		// 32 by 32 map at 1800h or at 1c00h with bg_map set
		map_addr = 13'(6144 + (lcdc_m.bg_map ? 1024 : 0) + int'(row / 8) * 32 + int'(col / 8));
		idx = vram[map_addr];
		// 16 bytes per tile with a signed index around 1000h when tile_sel is 0
		if (lcdc_m.tile_sel)
			base = 13'(int'(idx) * 16);
		else
			base = 13'(4096 + int'($signed(idx)) * 16);
		lo = vram[base + 13'(2 * int'(row % 8))];
		hi = vram[base + 13'(2 * int'(row % 8) + 1)];
		bit_pos = 7 - int'(col % 8);
		color = {hi[bit_pos], lo[bit_pos]};
		if (!lcdc_m.bg_ena)
			color = 2'd0;
		return bgp_m[int'(color) * 2 +: 2];
	endfunction

	// --------------------
	// register file
	task automatic register_access();
		reg_addr_e  regs [6] = '{REG_SCY, REG_SCX, REG_LYC, REG_BGP, REG_OBP0, REG_OBP1};
		logic [7:0] shadow [6];
		logic [7:0] got;
		logic [7:0] addr;
		// values after reset
		reg_read(REG_BGP, got);
		check_byte(got, 8'hfc, "BGP after reset");
		reg_read(REG_OBP0, got);
		check_byte(got, 8'hff, "OBP0 after reset");
		reg_read(REG_OBP1, got);
		check_byte(got, 8'hff, "OBP1 after reset");
		reg_read(REG_LCDC, got);
		check_byte(got, 8'h00, "LCDC after reset");
		// bit 7 and the lyc match set in hblank
		reg_read(REG_STAT, got);
		check_byte(got, 8'h84, "STAT after reset");
		for (int round = 0; round < 8; round++) begin
			// write them all first so aliasing shows up
			for (int i = 0; i < 6; i++) begin
				shadow[i] = 8'(rand_bits(8));
				reg_write(regs[i], shadow[i]);
			end
			for (int i = 0; i < 6; i++) begin
				reg_read(regs[i], got);
				check_byte(got, shadow[i], regs[i].name());
			end
		end
		// ly ignores writes
		reg_write(REG_LY, 8'(rand_bits(8)) | 8'h01);
		reg_read(REG_LY, got);
		check_byte(got, 8'h00, "LY after write");
		reg_read(8'h4a, got);
		check_byte(got, 8'hff, "unmapped 4Ah");
		reg_read(8'h3f, got);
		check_byte(got, 8'hff, "unmapped 3Fh");
		for (int i = 0; i < 8; i++) begin
			addr = 8'h50 + 8'(rand_bits(7));
			reg_read(addr, got);
			check_byte(got, 8'hff, "unmapped register");
		end
	endtask

	// --------------------
	// oam through the cpu port and then a dma run over it
	task automatic oam_dma_copy();
		logic [7:0] fill [OAM_BYTES];
		logic [7:0] page;
		logic [7:0] got;
		for (int i = 0; i < OAM_BYTES; i++) begin
			fill[i] = 8'(rand_bits(8));
			oam_write(8'(i), fill[i]);
		end
		for (int i = 0; i < OAM_BYTES; i++) begin
			oam_read(8'(i), got);
			check_byte(got, fill[i], "OAM byte from cpu");
		end
		page = 8'(rand_bits(8));
		reg_write(REG_DMA, page);
		// dma_rd is high from the cycle after the write for the whole run
		for (int i = 0; i < DMA_DOTS + 4; i++) begin
			check_byte({7'd0, dma_rd}, {7'd0, 1'(i < DMA_DOTS)}, "dma_rd");
			if (i < DMA_DOTS) begin
				check_byte(dma_addr[15:8], page, "dma page");
				check_byte(dma_addr[7:0], 8'(i / 4), "dma source offset");
			end
			@(negedge clk);
		end
		for (int i = 0; i < OAM_BYTES; i++) begin
			oam_read(8'(i), got);
			check_byte(got, 8'(i) ^ 8'ha5, "OAM byte after dma");
		end
	endtask

	// --------------------
	// per dot check of mode, ly, irq and pixels from the first dot after lcd on
	task automatic frame_timing(input int n_frames);
		logic [3:0] ena_q;
		logic [3:0] ena_new;
		logic       wr_stat;
		logic       lyc_hit;
		logic       exp_irq;
		ppu_mode_e  exp_mode;
		int         strobes;
		int         reads;
		ena_q = 4'd0;
		for (int f = 0; f < n_frames; f++) begin
			for (int line = 0; line < LINES_PER_FRAME; line++) begin
				strobes = 0;
				reads   = 0;
				for (int h = 0; h < DOTS_PER_LINE; h++) begin
					// draw lasts until the 160th strobe of this line
					if (line >= VISIBLE_LINES)
						exp_mode = MODE_VBLANK;
					else if (h < OAM_SCAN_DOTS)
						exp_mode = MODE_OAM;
					else if (strobes < SCREEN_W)
						exp_mode = MODE_DRAW;
					else
						exp_mode = MODE_HBLANK;
					lyc_hit = (line == int'(lyc_m));
					// one enable at a time rotated four times per line
					wr_stat = (h % 114 == 0);
					ena_new = 4'b0001 << ((h / 114 + line + f) % 4);
					if (wr_stat)
						drive_bus(1'b0, 1'b1, 1'b1, REG_STAT, {1'b0, ena_new, 3'b000});
					else if (f == 1)
						drive_bus(1'b0, 1'b1, 1'b0, REG_LY, 8'h00);
					else
						drive_bus(1'b0, 1'b1, 1'b0, REG_STAT, 8'h00);
					#(SAMPLE_DLY);
					if (f == 1 && !wr_stat) begin
						check_byte(cpu_rdata, 8'(line), "LY");
					end else begin
						check_mode(ppu_mode_e'(cpu_rdata[1:0]), exp_mode, "STAT mode");
						check_byte(cpu_rdata & 8'hfc, {1'b1, ena_q, lyc_hit, 2'b00}, "STAT");
					end
					exp_irq = (ena_q[3] && lyc_hit) ||
						(ena_q[2] && exp_mode == MODE_OAM) ||
						(ena_q[1] && exp_mode == MODE_VBLANK) ||
						(ena_q[0] && exp_mode == MODE_HBLANK);
					check_byte({4'd0, lcd_on, irq, vblank_irq, lcd_vsync},
						{4'd0, 1'b1, exp_irq, 1'(line >= VISIBLE_LINES), 1'(line == 0)},
						"lcd_on, irq, vblank_irq, vsync");
					// the fetcher only reads vram while drawing
					if (exp_mode != MODE_DRAW)
						check_byte({7'd0, vram_rd}, 8'h00, "vram_rd outside draw");
					if (vram_rd)
						reads++;
					if (lcd_clkena) begin
						if (exp_mode != MODE_DRAW)
							abort_run($sformatf("[FAIL] %0t ns: pixel strobe at dot %0d of line %0d",
								$time, h, line));
						check_pixel(lcd_data, model_pixel(strobes, line),
							$sformatf("pixel %0d of line %0d", strobes, line));
						strobes++;
					end
					// new enables apply from the next dot
					if (wr_stat)
						ena_q = ena_new;
					@(negedge clk);
				end
				if (line < VISIBLE_LINES) begin
					check_byte(8'(strobes), 8'(SCREEN_W), "strobes per line");
					// at least one full tile fetch for every eight pixels
					if (reads < int'(FETCH_DOTS * SCREEN_W / 8))
						abort_run($sformatf("[FAIL] %0t ns: only %0d vram read dots on line %0d",
							$time, reads, line));
				end
			end
		end
		drive_bus(1'b0, 1'b0, 1'b0, 8'h00, 8'h00);
	endtask

	// everything quiet with lcd off
	task automatic lcd_off_state(input string what);
		logic [7:0] got;
		reg_read(REG_LY, got);
		check_byte(got, 8'h00, {"LY ", what});
		reg_read(REG_STAT, got);
		check_mode(ppu_mode_e'(got[1:0]), MODE_HBLANK, {"mode ", what});
		check_byte({dma_rd, vram_rd, lcd_clkena, irq, vblank_irq, lcd_vsync, lcd_on, 1'b0},
			8'h00, {"output flags ", what});
		check_pixel(lcd_data, 2'd0, {"lcd_data ", what});
	endtask

	// --------------------
	initial begin
		error_count = 0;
		cycle_count = 0;
		lfsr_state  = 16'd85;
		reset       = 1'b1;
		cpu         = '0;
		// vram contents from the lfsr
		for (int a = 0; a < 8192; a++)
			vram[a] = 8'(rand_bits(8));
		repeat (16) @(negedge clk);
		reset = 1'b0;
		lcd_off_state("after reset");

		register_access();
		oam_dma_copy();

		// random scroll, palette and addressing for three frames with the lcd on
		scx_m = 8'(rand_bits(8));
		scy_m = 8'(rand_bits(8));
		bgp_m = 8'(rand_bits(8));
		lyc_m = 8'(rand_bits(8) % LINES_PER_FRAME);
		lcdc_m          = '0;
		lcdc_m.on       = 1'b1;
		lcdc_m.bg_ena   = 1'b1;
		lcdc_m.tile_sel = 1'(rand_bits(1));
		lcdc_m.bg_map   = 1'(rand_bits(1));
		reg_write(REG_SCX, scx_m);
		reg_write(REG_SCY, scy_m);
		reg_write(REG_BGP, bgp_m);
		reg_write(REG_LYC, lyc_m);
		reg_write(REG_STAT, 8'h00);
		reg_write(REG_LCDC, lcdc_m);
		frame_timing(3);

		reg_write(REG_LCDC, 8'h00);
		lcd_off_state("with lcd off");

		if (error_count == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			abort_run("errors were reported during the run");
		end
	end

endmodule
